// ==== sim.f ====
+incdir+include
source/gfx_pkg.sv
source/gfx_cmd_queue.sv
source/gfx_busy_tracker.sv
source/gfx_bus_slave.sv
source/gfx_reg_bank.sv
source/gfx_frontend_top.sv
test/gfx_tb.sv

// ==== include/gfx_tb_tasks.svh ====
// bus driver, compare and directed test tasks; included inside the gfx_tb module body
`ifndef GFX_TB_TASKS_SVH
`define GFX_TB_TASKS_SVH

  // one bus access, ends on ack or err
  task automatic bus_cycle(input logic write, input reg_adr_t adr, input word_t wdata,
                           input logic [3:0] sel, output word_t rdata,
                           output logic got_ack, output logic got_err);
    int waited;
    waited = 0;
    @(posedge clk_i);
    adr_i <= {GFX_BASE_HI, 8'h00, adr};
    dat_i <= wdata;
    sel_i <= sel;
    we_i  <= write;
    stb_i <= 1'b1;
    cyc_i <= 1'b1;
    @(posedge clk_i);
    while (ack_o !== 1'b1 && err_o !== 1'b1 && waited < BUS_WAIT_LIMIT)
    begin
      @(posedge clk_i);
      waited++;
    end
    got_ack = (ack_o === 1'b1);
    got_err = (err_o === 1'b1);
    rdata   = dat_o;
    stb_i <= 1'b0;
    cyc_i <= 1'b0;
    we_i  <= 1'b0;
    if (!got_ack && !got_err)
    begin
      $display("bus access to register %h got neither ack nor err", adr);
      err_count++;
    end
  endtask

  task automatic bus_write(input reg_adr_t adr, input word_t data);
    word_t rd;
    logic  got_ack;
    logic  got_err;
    bus_cycle(1'b1, adr, data, GFX_SEL_ALL, rd, got_ack, got_err);
    if (got_err)
    begin
      $display("full-width write to register %h was answered with err", adr);
      err_count++;
    end
  endtask

  task automatic bus_read(input reg_adr_t adr, output word_t data);
    logic got_ack;
    logic got_err;
    bus_cycle(1'b0, adr, '0, GFX_SEL_ALL, data, got_ack, got_err);
    if (got_err)
    begin
      $display("full-width read of register %h was answered with err", adr);
      err_count++;
    end
  endtask

  // poll status until the queue count is zero
  task automatic wait_drained();
    word_t stat_word;
    int    polls;
    polls = 0;
    bus_read(GFX_STATUS, stat_word);
    while (stat_word[31:16] != 16'd0 && polls < POLL_LIMIT)
    begin
      bus_read(GFX_STATUS, stat_word);
      polls++;
    end
    if (stat_word[31:16] != 16'd0)
    begin
      $display("command queue did not drain, %0d entries left", stat_word[31:16]);
      err_count++;
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("ERR %s: got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_point(input string name, input logic [POINT_WIDTH-1:0] got,
                             input logic [POINT_WIDTH-1:0] exp);
    if (got !== exp)
    begin
      $display("ERR %s: got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      $display("ERR %s: got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERR %s: got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before)
    begin
      $display("test %s: passed", name);
      tests_passed++;
    end
    else
    begin
      $display("test %s: failed with %0d errors", name, err_count - errs_before);
      tests_failed++;
    end
  endtask

  task automatic test_reset_values();
    word_t rd;
    int    errs_before;
    errs_before = err_count;
    check_byte("global_alpha_o", global_alpha_o, 8'hFF);
    check_byte("a0_o", a0_o, 8'hFF);
    check_bit("point_write_o", point_write_o, 1'b0);
    check_bit("rect_write_o", rect_write_o, 1'b0);
    check_bit("line_write_o", line_write_o, 1'b0);
    check_bit("triangle_write_o", triangle_write_o, 1'b0);
    check_bit("texture_enable_o", texture_enable_o, 1'b0);
    check_bit("blending_enable_o", blending_enable_o, 1'b0);
    check_bit("clipping_enable_o", clipping_enable_o, 1'b0);
    check_bit("inta_o", inta_o, 1'b0);
    bus_read(GFX_CONTROL, rd);
    check_word("dat_o control", rd, '0);
    bus_read(GFX_ALPHA, rd);
    check_word("dat_o alpha", rd, ALPHA_RESET);
    bus_read(GFX_STATUS, rd);
    check_word("dat_o status", rd, '0);
    report_test("reset values", errs_before);
  endtask

  task automatic test_write_readback();
    reg_adr_t adrs [10];
    word_t    vals [10];
    word_t    rd;
    int       errs_before;
    errs_before = err_count;
    adrs[0] = GFX_TARGET_BASE;
    adrs[1] = GFX_TARGET_SIZE_X;
    adrs[2] = GFX_TARGET_SIZE_Y;
    adrs[3] = GFX_SRC_PIXEL0_X;
    adrs[4] = GFX_SRC_PIXEL0_Y;
    adrs[5] = GFX_SRC_PIXEL1_X;
    adrs[6] = GFX_SRC_PIXEL1_Y;
    adrs[7] = GFX_DEST_PIXEL_X;
    adrs[8] = GFX_DEST_PIXEL_Y;
    adrs[9] = GFX_COLOR0;
    for (int i = 0; i < 10; i++)
    begin
      vals[i] = next_rand_word();
      bus_write(adrs[i], vals[i]);
    end
    wait_drained();
    check_word("target_base_o", target_base_o, vals[0]);
    // sizes and source pixels are the low bits only
    check_point("target_size_x_o", target_size_x_o, vals[1][POINT_WIDTH-1:0]);
    check_point("target_size_y_o", target_size_y_o, vals[2][POINT_WIDTH-1:0]);
    check_point("src_pixel0_x_o", src_pixel0_x_o, vals[3][POINT_WIDTH-1:0]);
    check_point("src_pixel0_y_o", src_pixel0_y_o, vals[4][POINT_WIDTH-1:0]);
    check_point("src_pixel1_x_o", src_pixel1_x_o, vals[5][POINT_WIDTH-1:0]);
    check_point("src_pixel1_y_o", src_pixel1_y_o, vals[6][POINT_WIDTH-1:0]);
    check_word("dest_pixel_x_o", word_t'(dest_pixel_x_o), vals[7]);
    check_word("dest_pixel_y_o", word_t'(dest_pixel_y_o), vals[8]);
    check_word("color0_o", color0_o, vals[9]);
    for (int i = 0; i < 10; i++)
    begin
      bus_read(adrs[i], rd);
      check_word("dat_o", rd, vals[i]);
    end
    report_test("write and read back", errs_before);
  endtask

  task automatic test_control_decode();
    word_t      ctrl;
    word_t      alpha;
    word_t      rd;
    logic [2:0] depth;
    logic       en;
    int         errs_before;
    errs_before = err_count;
    for (int k = 0; k < 2; k++)
    begin
      depth = (k == 0) ? 3'd5 : 3'd2;
      en    = (k == 0);
      ctrl  = '0;
      ctrl[GFX_CTRL_COLOR_DEPTH +: 3] = depth;
      ctrl[GFX_CTRL_TEXTURE]          = en;
      ctrl[GFX_CTRL_BLENDING]         = ~en;
      ctrl[GFX_CTRL_CLIPPING]         = en;
      bus_write(GFX_CONTROL, ctrl);
      wait_drained();
      check_byte("color_depth_o", {5'b0, color_depth_o}, {5'b0, depth});
      check_bit("texture_enable_o", texture_enable_o, en);
      check_bit("blending_enable_o", blending_enable_o, ~en);
      check_bit("clipping_enable_o", clipping_enable_o, en);
      bus_read(GFX_CONTROL, rd);
      check_word("dat_o control", rd, ctrl);
    end
    alpha = next_rand_word();
    bus_write(GFX_ALPHA, alpha);
    wait_drained();
    check_byte("a0_o", a0_o, alpha[31:24]);
    check_byte("a1_o", a1_o, alpha[23:16]);
    check_byte("a2_o", a2_o, alpha[15:8]);
    check_byte("global_alpha_o", global_alpha_o, alpha[7:0]);
    report_test("control decode", errs_before);
  endtask

  task automatic test_trigger_busy();
    word_t old_color;
    word_t c1;
    word_t c2;
    word_t base_val;
    word_t ctrl;
    word_t stat_word;
    word_t exp_stat;
    int    rect_before;
    int    other_before;
    int    polls;
    int    errs_before;
    errs_before = err_count;
    old_color = next_rand_word();
    c1        = next_rand_word();
    c2        = next_rand_word();
    base_val  = next_rand_word();
    bus_write(GFX_COLOR0, old_color);
    wait_drained();
    rect_before  = rect_cycles;
    other_before = other_trig_cycles;
    ctrl = '0;
    ctrl[GFX_CTRL_RECT] = 1'b1;
    bus_write(GFX_CONTROL, ctrl);
    polls = 0;
    bus_read(GFX_STATUS, stat_word);
    while (stat_word[GFX_STAT_BUSY] !== 1'b1 && polls < POLL_LIMIT)
    begin
      bus_read(GFX_STATUS, stat_word);
      polls++;
    end
    if (stat_word[GFX_STAT_BUSY] !== 1'b1)
    begin
      $display("core did not report busy after the rect trigger");
      err_count++;
    end
    // these must stay queued while busy
    bus_write(GFX_COLOR0, c1);
    bus_write(GFX_COLOR0, c2);
    bus_write(GFX_TARGET_BASE, base_val);
    exp_stat = '0;
    exp_stat[31:16]         = 16'd3;
    exp_stat[GFX_STAT_BUSY] = 1'b1;
    bus_read(GFX_STATUS, stat_word);
    check_word("dat_o status while busy", stat_word, exp_stat);
    check_word("color0_o while busy", color0_o, old_color);
    bus_read(GFX_CONTROL, stat_word);
    check_word("dat_o control after trigger", stat_word, '0);
    @(posedge clk_i);
    pipeline_ack_i <= 1'b1;
    @(posedge clk_i);
    pipeline_ack_i <= 1'b0;
    wait_drained();
    bus_read(GFX_STATUS, stat_word);
    check_word("dat_o status after ack", stat_word, '0);
    // second color0 write is the later one
    check_word("color0_o", color0_o, c2);
    check_word("target_base_o", target_base_o, base_val);
    check_word("rect_write_o cycles high", word_t'(rect_cycles - rect_before), 32'd1);
    check_word("other trigger cycles high", word_t'(other_trig_cycles - other_before), '0);
    report_test("trigger and busy", errs_before);
  endtask

  task automatic test_partial_access();
    word_t good;
    word_t rd;
    logic  got_ack;
    logic  got_err;
    int    errs_before;
    errs_before = err_count;
    good = next_rand_word();
    bus_write(GFX_TARGET_BASE, good);
    wait_drained();
    bus_cycle(1'b1, GFX_TARGET_BASE, ~good, 4'b0011, rd, got_ack, got_err);
    check_bit("err_o on partial write", got_err, 1'b1);
    check_bit("ack_o on partial write", got_ack, 1'b0);
    bus_cycle(1'b0, GFX_TARGET_BASE, '0, 4'b1000, rd, got_ack, got_err);
    check_bit("err_o on partial read", got_err, 1'b1);
    check_bit("ack_o on partial read", got_ack, 1'b0);
    wait_drained();
    bus_read(GFX_TARGET_BASE, rd);
    check_word("dat_o target base", rd, good);
    check_word("target_base_o", target_base_o, good);
    report_test("partial access", errs_before);
  endtask

  task automatic test_interrupt();
    int errs_before;
    errs_before = err_count;
    check_bit("inta_o idle", inta_o, 1'b0);
    @(posedge clk_i);
    writer_sint_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    check_bit("inta_o from writer", inta_o, 1'b1);
    writer_sint_i <= 1'b0;
    reader_sint_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    check_bit("inta_o from reader", inta_o, 1'b1);
    reader_sint_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    check_bit("inta_o cleared", inta_o, 1'b0);
    report_test("interrupt", errs_before);
  endtask

`endif

// ==== test/gfx_tb.sv ====
// testbench of the graphics register front end; runs the directed tests from gfx_tb_tasks.svh
`timescale 1ns/1ps

module gfx_tb
  import gfx_pkg::*;
;

  localparam int POINT_WIDTH      = 16;
  localparam int QUEUE_DEPTH_BITS = 6;
  localparam int N_TESTS          = 6;
  localparam int WATCHDOG_CYCLES  = N_TESTS * 2000;
  localparam int BUS_WAIT_LIMIT   = 100;
  localparam int POLL_LIMIT       = 40;

  logic                   clk_i = 1'b0;
  logic                   rst_i;
  logic [31:0]            adr_i;
  word_t                  dat_i;
  word_t                  dat_o;
  logic [3:0]             sel_i;
  logic                   we_i;
  logic                   stb_i;
  logic                   cyc_i;
  logic                   ack_o;
  logic                   err_o;
  logic                   inta_o;
  logic                   writer_sint_i;
  logic                   reader_sint_i;
  logic                   pipeline_ack_i;
  logic                   point_write_o;
  logic                   rect_write_o;
  logic                   line_write_o;
  logic                   triangle_write_o;
  logic [2:0]             color_depth_o;
  logic                   texture_enable_o;
  logic                   blending_enable_o;
  logic                   clipping_enable_o;
  word_t                  target_base_o;
  logic [POINT_WIDTH-1:0] target_size_x_o;
  logic [POINT_WIDTH-1:0] target_size_y_o;
  logic [POINT_WIDTH-1:0] src_pixel0_x_o;
  logic [POINT_WIDTH-1:0] src_pixel0_y_o;
  logic [POINT_WIDTH-1:0] src_pixel1_x_o;
  logic [POINT_WIDTH-1:0] src_pixel1_y_o;
  logic signed [31:0]     dest_pixel_x_o;
  logic signed [31:0]     dest_pixel_y_o;
  word_t                  color0_o;
  logic [7:0]             a0_o;
  logic [7:0]             a1_o;
  logic [7:0]             a2_o;
  logic [7:0]             global_alpha_o;

  int          err_count         = 0;
  int          tests_passed      = 0;
  int          tests_failed      = 0;
  int          rect_cycles       = 0;
  int          other_trig_cycles = 0;
  logic [15:0] lfsr_state        = 16'd9170;

  always #2 clk_i = ~clk_i;

  gfx_frontend_top #(
    .POINT_WIDTH(POINT_WIDTH),
    .QUEUE_DEPTH_BITS(QUEUE_DEPTH_BITS)
  ) uut (
    .clk_i(clk_i), .rst_i(rst_i),
    .adr_i(adr_i), .dat_i(dat_i), .dat_o(dat_o), .sel_i(sel_i),
    .we_i(we_i), .stb_i(stb_i), .cyc_i(cyc_i),
    .ack_o(ack_o), .err_o(err_o), .inta_o(inta_o),
    .writer_sint_i(writer_sint_i), .reader_sint_i(reader_sint_i),
    .pipeline_ack_i(pipeline_ack_i),
    .point_write_o(point_write_o), .rect_write_o(rect_write_o),
    .line_write_o(line_write_o), .triangle_write_o(triangle_write_o),
    .color_depth_o(color_depth_o), .texture_enable_o(texture_enable_o),
    .blending_enable_o(blending_enable_o), .clipping_enable_o(clipping_enable_o),
    .target_base_o(target_base_o),
    .target_size_x_o(target_size_x_o), .target_size_y_o(target_size_y_o),
    .src_pixel0_x_o(src_pixel0_x_o), .src_pixel0_y_o(src_pixel0_y_o),
    .src_pixel1_x_o(src_pixel1_x_o), .src_pixel1_y_o(src_pixel1_y_o),
    .dest_pixel_x_o(dest_pixel_x_o), .dest_pixel_y_o(dest_pixel_y_o),
    .color0_o(color0_o),
    .a0_o(a0_o), .a1_o(a1_o), .a2_o(a2_o), .global_alpha_o(global_alpha_o)
  );

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit
  function word_t next_rand_word();
    word_t w;
    w = '0;
    for (int b = 0; b < 32; b++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
    return w;
  endfunction

  // count the cycles each draw trigger is high
  always @(posedge clk_i)
  begin
    if (rect_write_o === 1'b1)
    begin
      rect_cycles <= rect_cycles + 1;
    end
    if ((point_write_o | line_write_o | triangle_write_o) !== 1'b0)
    begin
      other_trig_cycles <= other_trig_cycles + 1;
    end
  end

`include "gfx_tb_tasks.svh"

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, tests did not complete", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    rst_i          <= 1'b1;
    adr_i          <= '0;
    dat_i          <= '0;
    sel_i          <= '0;
    we_i           <= 1'b0;
    stb_i          <= 1'b0;
    cyc_i          <= 1'b0;
    writer_sint_i  <= 1'b0;
    reader_sint_i  <= 1'b0;
    pipeline_ack_i <= 1'b0;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);
    test_reset_values();
    test_write_readback();
    test_control_decode();
    test_trigger_busy();
    test_partial_access();
    test_interrupt();
    $display("tests passed %0d, tests failed %0d, failed checks %0d",
             tests_passed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0)
    begin
      $display("TEST OK");
    end
    else
    begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== source/gfx_frontend_top.sv ====
// top of the graphics register front end: bus slave, command queue, busy FSM and register bank
`timescale 1ns/1ps

module gfx_frontend_top
  import gfx_pkg::*;
#(
  parameter int POINT_WIDTH      = 16,
  parameter int QUEUE_DEPTH_BITS = 6
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic [31:0]            adr_i,
  input  word_t                  dat_i,
  output word_t                  dat_o,
  input  logic [3:0]             sel_i,
  input  logic                   we_i,
  input  logic                   stb_i,
  input  logic                   cyc_i,
  output logic                   ack_o,
  output logic                   err_o,
  output logic                   inta_o,
  input  logic                   writer_sint_i,
  input  logic                   reader_sint_i,
  input  logic                   pipeline_ack_i,
  output logic                   point_write_o,
  output logic                   rect_write_o,
  output logic                   line_write_o,
  output logic                   triangle_write_o,
  output logic [2:0]             color_depth_o,
  output logic                   texture_enable_o,
  output logic                   blending_enable_o,
  output logic                   clipping_enable_o,
  output word_t                  target_base_o,
  output logic [POINT_WIDTH-1:0] target_size_x_o,
  output logic [POINT_WIDTH-1:0] target_size_y_o,
  output logic [POINT_WIDTH-1:0] src_pixel0_x_o,
  output logic [POINT_WIDTH-1:0] src_pixel0_y_o,
  output logic [POINT_WIDTH-1:0] src_pixel1_x_o,
  output logic [POINT_WIDTH-1:0] src_pixel1_y_o,
  output logic signed [31:0]     dest_pixel_x_o,
  output logic signed [31:0]     dest_pixel_y_o,
  output word_t                  color0_o,
  output logic [7:0]             a0_o,
  output logic [7:0]             a1_o,
  output logic [7:0]             a2_o,
  output logic [7:0]             global_alpha_o
);

  logic                    q_full;
  logic                    q_enq;
  gfx_cmd_t                q_cmd;
  logic                    q_valid;
  gfx_cmd_t                q_head;
  logic                    q_deq;
  logic [QUEUE_DEPTH_BITS:0] q_count;
  logic [15:0]             status_count;
  reg_adr_t                rd_adr;
  word_t                   rd_data;
  logic                    busy;

  // status word field is 16 bits wide
  assign status_count = 16'(q_count);

  gfx_bus_slave u_slave (
    .clk_i(clk_i), .rst_i(rst_i),
    .adr_i(adr_i), .dat_i(dat_i), .sel_i(sel_i), .we_i(we_i),
    .stb_i(stb_i), .cyc_i(cyc_i),
    .dat_o(dat_o), .ack_o(ack_o), .err_o(err_o),
    .writer_sint_i(writer_sint_i), .reader_sint_i(reader_sint_i), .inta_o(inta_o),
    .full_i(q_full), .enq_o(q_enq), .cmd_o(q_cmd),
    .rd_adr_o(rd_adr), .rd_data_i(rd_data)
  );

  gfx_cmd_queue #(
    .PAYLOAD_T(gfx_cmd_t),
    .DEPTH_BITS(QUEUE_DEPTH_BITS)
  ) u_queue (
    .clk_i(clk_i), .rst_i(rst_i),
    .enq_i(q_enq), .data_i(q_cmd), .full_o(q_full), .count_o(q_count),
    .valid_o(q_valid), .data_o(q_head), .deq_i(q_deq)
  );

  gfx_busy_tracker u_tracker (
    .clk_i(clk_i), .rst_i(rst_i),
    .trigger_i({triangle_write_o, line_write_o, rect_write_o, point_write_o}),
    .pipeline_ack_i(pipeline_ack_i),
    .busy_o(busy)
  );

  gfx_reg_bank #(
    .POINT_WIDTH(POINT_WIDTH)
  ) u_regs (
    .clk_i(clk_i), .rst_i(rst_i),
    .valid_i(q_valid), .head_i(q_head), .count_i(status_count), .deq_o(q_deq),
    .busy_i(busy), .rd_adr_i(rd_adr), .rd_data_o(rd_data),
    .point_write_o(point_write_o), .rect_write_o(rect_write_o),
    .line_write_o(line_write_o), .triangle_write_o(triangle_write_o),
    .color_depth_o(color_depth_o), .texture_enable_o(texture_enable_o),
    .blending_enable_o(blending_enable_o), .clipping_enable_o(clipping_enable_o),
    .target_base_o(target_base_o),
    .target_size_x_o(target_size_x_o), .target_size_y_o(target_size_y_o),
    .src_pixel0_x_o(src_pixel0_x_o), .src_pixel0_y_o(src_pixel0_y_o),
    .src_pixel1_x_o(src_pixel1_x_o), .src_pixel1_y_o(src_pixel1_y_o),
    .dest_pixel_x_o(dest_pixel_x_o), .dest_pixel_y_o(dest_pixel_y_o),
    .color0_o(color0_o),
    .a0_o(a0_o), .a1_o(a1_o), .a2_o(a2_o), .global_alpha_o(global_alpha_o)
  );

endmodule

// ==== source/gfx_reg_bank.sv ====
// register bank of the core: applies queued writes while idle, decodes fields, serves reads
`timescale 1ns/1ps

module gfx_reg_bank
  import gfx_pkg::*;
#(
  parameter int POINT_WIDTH = 16
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    valid_i,
  input  gfx_cmd_t                head_i,
  input  logic [15:0]             count_i,
  output logic                    deq_o,
  input  logic                    busy_i,
  input  reg_adr_t                rd_adr_i,
  output word_t                   rd_data_o,
  output logic                    point_write_o,
  output logic                    rect_write_o,
  output logic                    line_write_o,
  output logic                    triangle_write_o,
  output logic [2:0]              color_depth_o,
  output logic                    texture_enable_o,
  output logic                    blending_enable_o,
  output logic                    clipping_enable_o,
  output word_t                   target_base_o,
  output logic [POINT_WIDTH-1:0]  target_size_x_o,
  output logic [POINT_WIDTH-1:0]  target_size_y_o,
  output logic [POINT_WIDTH-1:0]  src_pixel0_x_o,
  output logic [POINT_WIDTH-1:0]  src_pixel0_y_o,
  output logic [POINT_WIDTH-1:0]  src_pixel1_x_o,
  output logic [POINT_WIDTH-1:0]  src_pixel1_y_o,
  output logic signed [31:0]      dest_pixel_x_o,
  output logic signed [31:0]      dest_pixel_y_o,
  output word_t                   color0_o,
  output logic [7:0]              a0_o,
  output logic [7:0]              a1_o,
  output logic [7:0]              a2_o,
  output logic [7:0]              global_alpha_o
);

  word_t              control_q;
  word_t              alpha_q;
  word_t              target_base_q;
  word_t              target_size_x_q;
  word_t              target_size_y_q;
  word_t              src_pixel0_x_q;
  word_t              src_pixel0_y_q;
  word_t              src_pixel1_x_q;
  word_t              src_pixel1_y_q;
  logic signed [31:0] dest_pixel_x_q;
  logic signed [31:0] dest_pixel_y_q;
  word_t              color0_q;
  word_t              status_w;
  logic               trigger_w;

  assign trigger_w = control_q[GFX_CTRL_POINT] | control_q[GFX_CTRL_RECT] |
                     control_q[GFX_CTRL_LINE] | control_q[GFX_CTRL_TRI];

  // hold the queue while the pipeline runs or is about to start
  assign deq_o = valid_i & ~busy_i & ~trigger_w;

  // control and alpha
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      control_q <= '0;
      alpha_q   <= ALPHA_RESET;
    end
    else
    begin
      // triggers self-clear, a control write below takes priority
      control_q[GFX_CTRL_POINT] <= 1'b0;
      control_q[GFX_CTRL_RECT]  <= 1'b0;
      control_q[GFX_CTRL_LINE]  <= 1'b0;
      control_q[GFX_CTRL_TRI]   <= 1'b0;
      if (deq_o)
      begin
        case (head_i.adr)
          GFX_CONTROL: control_q <= head_i.data;
          GFX_ALPHA:   alpha_q   <= head_i.data;
          default:     ;
        endcase
      end
    end
  end

  // geometry and color registers
  always_ff @(posedge clk_i)
  begin
    if (deq_o)
    begin
      case (head_i.adr)
        GFX_TARGET_BASE:   target_base_q   <= head_i.data;
        GFX_TARGET_SIZE_X: target_size_x_q <= head_i.data;
        GFX_TARGET_SIZE_Y: target_size_y_q <= head_i.data;
        GFX_SRC_PIXEL0_X:  src_pixel0_x_q  <= head_i.data;
        GFX_SRC_PIXEL0_Y:  src_pixel0_y_q  <= head_i.data;
        GFX_SRC_PIXEL1_X:  src_pixel1_x_q  <= head_i.data;
        GFX_SRC_PIXEL1_Y:  src_pixel1_y_q  <= head_i.data;
        GFX_DEST_PIXEL_X:  dest_pixel_x_q  <= $signed(head_i.data);
        GFX_DEST_PIXEL_Y:  dest_pixel_y_q  <= $signed(head_i.data);
        GFX_COLOR0:        color0_q        <= head_i.data;
        // status and unmapped addresses are dropped
        default:           ;
      endcase
    end
  end

  // control decode
  assign color_depth_o     = control_q[GFX_CTRL_COLOR_DEPTH+2:GFX_CTRL_COLOR_DEPTH];
  assign texture_enable_o  = control_q[GFX_CTRL_TEXTURE];
  assign blending_enable_o = control_q[GFX_CTRL_BLENDING];
  assign clipping_enable_o = control_q[GFX_CTRL_CLIPPING];
  assign point_write_o     = control_q[GFX_CTRL_POINT];
  assign rect_write_o      = control_q[GFX_CTRL_RECT];
  assign line_write_o      = control_q[GFX_CTRL_LINE];
  assign triangle_write_o  = control_q[GFX_CTRL_TRI];

  // vertex alphas from the high byte down, global alpha last
  assign a0_o           = alpha_q[31:24];
  assign a1_o           = alpha_q[23:16];
  assign a2_o           = alpha_q[15:8];
  assign global_alpha_o = alpha_q[7:0];

  assign target_base_o   = target_base_q;
  assign target_size_x_o = target_size_x_q[POINT_WIDTH-1:0];
  assign target_size_y_o = target_size_y_q[POINT_WIDTH-1:0];
  assign src_pixel0_x_o  = src_pixel0_x_q[POINT_WIDTH-1:0];
  assign src_pixel0_y_o  = src_pixel0_y_q[POINT_WIDTH-1:0];
  assign src_pixel1_x_o  = src_pixel1_x_q[POINT_WIDTH-1:0];
  assign src_pixel1_y_o  = src_pixel1_y_q[POINT_WIDTH-1:0];
  assign dest_pixel_x_o  = dest_pixel_x_q;
  assign dest_pixel_y_o  = dest_pixel_y_q;
  assign color0_o        = color0_q;

  always_comb
  begin
    status_w                = '0;
    status_w[31:16]         = count_i;
    status_w[GFX_STAT_BUSY] = busy_i;
  end

  // read mux, pending queue entries are not visible here
  always_comb
  begin
    case (rd_adr_i)
      GFX_CONTROL:       rd_data_o = control_q;
      GFX_STATUS:        rd_data_o = status_w;
      GFX_ALPHA:         rd_data_o = alpha_q;
      GFX_TARGET_BASE:   rd_data_o = target_base_q;
      GFX_TARGET_SIZE_X: rd_data_o = target_size_x_q;
      GFX_TARGET_SIZE_Y: rd_data_o = target_size_y_q;
      GFX_SRC_PIXEL0_X:  rd_data_o = src_pixel0_x_q;
      GFX_SRC_PIXEL0_Y:  rd_data_o = src_pixel0_y_q;
      GFX_SRC_PIXEL1_X:  rd_data_o = src_pixel1_x_q;
      GFX_SRC_PIXEL1_Y:  rd_data_o = src_pixel1_y_q;
      GFX_DEST_PIXEL_X:  rd_data_o = dest_pixel_x_q;
      GFX_DEST_PIXEL_Y:  rd_data_o = dest_pixel_y_q;
      GFX_COLOR0:        rd_data_o = color0_q;
      default:           rd_data_o = '0;
    endcase
  end

  // a command held back while busy or triggering must wait unchanged at the head
  assert property (@(posedge clk_i) disable iff (rst_i)
                   valid_i && !deq_o |=> $stable(head_i))
    else $error("queue head changed before it was applied");

endmodule

// ==== source/gfx_bus_slave.sv ====
// Wishbone-style slave of the core: decodes accesses, queues writes, returns read data
`timescale 1ns/1ps

module gfx_bus_slave
  import gfx_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [31:0] adr_i,
  input  word_t       dat_i,
  input  logic [3:0]  sel_i,
  input  logic        we_i,
  input  logic        stb_i,
  input  logic        cyc_i,
  output word_t       dat_o,
  output logic        ack_o,
  output logic        err_o,
  input  logic        writer_sint_i,
  input  logic        reader_sint_i,
  output logic        inta_o,
  input  logic        full_i,
  output logic        enq_o,
  output gfx_cmd_t    cmd_o,
  output reg_adr_t    rd_adr_o,
  input  word_t       rd_data_i
);

  logic     cs_w;
  logic     sel_full_w;
  logic     req_w;
  reg_adr_t reg_adr_w;

  // chip select on the upper address half
  assign cs_w       = cyc_i & stb_i & (adr_i[31:16] == GFX_BASE_HI);
  assign sel_full_w = (sel_i == GFX_SEL_ALL);

  // writes wait in wait states while the queue is full
  assign req_w = cs_w & sel_full_w & ~(we_i & full_i);

  assign reg_adr_w = {adr_i[7:2], 2'b00};
  assign rd_adr_o  = reg_adr_w;

  // enqueue on the cycle the ack gets registered, so only once per access
  assign enq_o      = req_w & we_i & ~ack_o;
  assign cmd_o.adr  = reg_adr_w;
  assign cmd_o.data = dat_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      ack_o  <= 1'b0;
      err_o  <= 1'b0;
      inta_o <= 1'b0;
    end
    else
    begin
      ack_o  <= req_w & ~ack_o;
      // partial-width access gets a single error pulse
      err_o  <= cs_w & ~sel_full_w & ~err_o;
      inta_o <= writer_sint_i | reader_sint_i;
    end
  end

  // read data lines up with the ack
  always_ff @(posedge clk_i)
  begin
    if (cs_w & sel_full_w & ~we_i)
    begin
      dat_o <= rd_data_i;
    end
    else
    begin
      dat_o <= '0;
    end
  end

  // a write held off by a full queue has to stay on the bus until it is taken
  assert property (@(posedge clk_i) disable iff (rst_i)
                   cs_w && sel_full_w && we_i && full_i |=> cs_w)
    else $error("write request withdrawn while command queue full");

endmodule

// ==== source/gfx_busy_tracker.sv ====
// wait/busy FSM of the drawing pipeline; busy from a draw trigger until the pipeline ack
`timescale 1ns/1ps

module gfx_busy_tracker (
  input  logic       clk_i,
  input  logic       rst_i,
  input  logic [3:0] trigger_i,
  input  logic       pipeline_ack_i,
  output logic       busy_o
);

  typedef enum logic {
    ST_WAIT = 1'b0,
    ST_BUSY = 1'b1
  } state_t;

  state_t state_q;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q <= ST_WAIT;
    end
    else
    begin
      case (state_q)
        ST_WAIT:
        begin
          // any draw trigger starts a pipeline operation
          if (|trigger_i)
          begin
            state_q <= ST_BUSY;
          end
        end
        ST_BUSY:
        begin
          if (pipeline_ack_i)
          begin
            state_q <= ST_WAIT;
          end
        end
        default: state_q <= ST_WAIT;
      endcase
    end
  end

  assign busy_o = (state_q == ST_BUSY);

  // register bank must drop the trigger after one cycle and then see us busy
  assert property (@(posedge clk_i) disable iff (rst_i) |trigger_i |=> !(|trigger_i) && busy_o)
    else $error("draw trigger held longer than one cycle");

endmodule

// ==== source/gfx_cmd_queue.sv ====
// synchronous FIFO of pending commands; payload type set by the instantiating module
`timescale 1ns/1ps

module gfx_cmd_queue #(
  parameter type PAYLOAD_T  = logic [39:0],
  parameter int  DEPTH_BITS = 6
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              enq_i,
  input  PAYLOAD_T          data_i,
  output logic              full_o,
  output logic [DEPTH_BITS:0] count_o,
  output logic              valid_o,
  output PAYLOAD_T          data_o,
  input  logic              deq_i
);

  localparam int DEPTH = 1 << DEPTH_BITS;

  PAYLOAD_T mem [DEPTH];

  logic [DEPTH_BITS-1:0] wr_ptr;
  logic [DEPTH_BITS-1:0] rd_ptr;
  logic [DEPTH_BITS:0]   count_q;
  logic                  do_enq;
  logic                  do_deq;

  assign full_o  = (count_q == DEPTH[DEPTH_BITS:0]);
  assign valid_o = (count_q != '0);
  assign count_o = count_q;

  // head is read straight from the array
  assign data_o = mem[rd_ptr];

  assign do_enq = enq_i & ~full_o;
  assign do_deq = deq_i & valid_o;

  always_ff @(posedge clk_i)
  begin
    if (do_enq)
    begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
    end
    else
    begin
      if (do_enq)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_deq)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous enqueue and dequeue leaves the count alone
      case ({do_enq, do_deq})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // producer and consumer must honour the flags
  assert property (@(posedge clk_i) disable iff (rst_i) deq_i |-> valid_o)
    else $error("command queue dequeued while empty");

  assert property (@(posedge clk_i) disable iff (rst_i) enq_i |-> !full_o)
    else $error("command queue enqueued while full");

endmodule

// ==== source/gfx_pkg.sv ====
// shared types, register map and control bit positions; imported by every module of the core
package gfx_pkg;

  // bus data word
  typedef logic [31:0] word_t;

  // byte address of a register inside the core, low two bits always zero
  typedef logic [7:0] reg_adr_t;

  // one queued register write
  typedef struct packed {
    reg_adr_t adr;
    word_t    data;
  } gfx_cmd_t;

  // address high half that selects the core
  localparam logic [15:0] GFX_BASE_HI = 16'hFFD4;

  // byte select pattern of a full-width access
  localparam logic [3:0] GFX_SEL_ALL = 4'b1111;

  // register map
  localparam reg_adr_t GFX_CONTROL       = 8'h00;
  localparam reg_adr_t GFX_STATUS        = 8'h04;
  localparam reg_adr_t GFX_ALPHA         = 8'h08;
  localparam reg_adr_t GFX_TARGET_BASE   = 8'h0C;
  localparam reg_adr_t GFX_TARGET_SIZE_X = 8'h10;
  localparam reg_adr_t GFX_TARGET_SIZE_Y = 8'h14;
  localparam reg_adr_t GFX_SRC_PIXEL0_X  = 8'h18;
  localparam reg_adr_t GFX_SRC_PIXEL0_Y  = 8'h1C;
  localparam reg_adr_t GFX_SRC_PIXEL1_X  = 8'h20;
  localparam reg_adr_t GFX_SRC_PIXEL1_Y  = 8'h24;
  localparam reg_adr_t GFX_DEST_PIXEL_X  = 8'h28;
  localparam reg_adr_t GFX_DEST_PIXEL_Y  = 8'h2C;
  localparam reg_adr_t GFX_COLOR0        = 8'h30;

  // control register fields
  // color depth takes three bits starting here
  localparam int GFX_CTRL_COLOR_DEPTH = 0;
  localparam int GFX_CTRL_TEXTURE     = 3;
  localparam int GFX_CTRL_BLENDING    = 4;
  localparam int GFX_CTRL_CLIPPING    = 5;

  // draw triggers, each lives for one cycle
  localparam int GFX_CTRL_POINT = 8;
  localparam int GFX_CTRL_RECT  = 9;
  localparam int GFX_CTRL_LINE  = 10;
  localparam int GFX_CTRL_TRI   = 11;

  // status word: busy in bit 0, queue count in bits 31..16
  localparam int GFX_STAT_BUSY = 0;

  // all alphas opaque after reset
  localparam word_t ALPHA_RESET = 32'hFFFF_FFFF;

endpackage
